/* logic/cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// geometry of the direct-mapped cache
	localparam int tag_bits = 5;
	localparam int index_bits = 7;
	localparam int offset_bits = 3;
	localparam int sets = 2**index_bits;         // 128 sets
	localparam int block_words = 2**offset_bits; // also the number of banks
	localparam int word_bits = 16;

	// a cpu address seen either as one word or split into its cache fields
	typedef union packed {
		logic [word_bits-1:0] word;
		struct packed {
			logic [tag_bits-1:0] tag;
			logic [index_bits-1:0] index;
			logic [offset_bits-1:0] offset;
			logic byte_sel; // ignored, memory is word addressed
		} fields;
	} cache_addr_t;

	typedef enum logic [2:0] {
		idle,
		lookup,
		fill,
		fill_done,
		write_mem
	} ctrl_state_t;

endpackage

`default_nettype wire

/* logic/word_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module word_bank (
	input  logic clk,
	input  logic write_en,
	input  logic [cache_pkg::index_bits-1:0] index,
	input  logic [cache_pkg::word_bits-1:0] write_data,
	output logic [cache_pkg::word_bits-1:0] read_data
);
	import cache_pkg::*;

	// one word of every set
	logic [word_bits-1:0] mem [2**index_bits];

	always_ff @(posedge clk) begin
		if (write_en)
			mem[index] <= write_data;
		read_data <= mem[index]; // old data when written on the same edge
	end

endmodule

`default_nettype wire

/* logic/read_select.sv */
`timescale 1ns/10ps
`default_nettype none

module read_select (
	input  logic clk,
	input  logic rst_n,
	input  logic [cache_pkg::offset_bits-1:0] word_offset,
	input  logic [cache_pkg::word_bits-1:0] bank_words [2**cache_pkg::offset_bits],
	output logic [cache_pkg::word_bits-1:0] prdata
);
	import cache_pkg::*;

	logic [offset_bits-1:0] offset_q;
	logic primed; // banks have been read at least once

	// the offset is taken on the same edge the banks read the set
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			offset_q <= '0;
			primed <= 1'b0;
		end else begin
			offset_q <= word_offset;
			primed <= 1'b1;
		end
	end

	assign prdata = primed ? bank_words[offset_q] : '0;

endmodule

`default_nettype wire

/* logic/cache_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_ctrl (
	input  logic clk,
	input  logic rst_n,

	// apb slave
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  cache_pkg::cache_addr_t paddr,
	input  logic [cache_pkg::word_bits-1:0] pwdata,
	output logic pready,

	// memory port
	input  logic mem_ready,
	input  logic [cache_pkg::word_bits-1:0] mem_read_data,
	output logic mem_read,
	output logic mem_write,
	output logic [cache_pkg::word_bits-1:0] mem_addr,
	output logic [cache_pkg::word_bits-1:0] mem_write_data,

	// data banks and read select
	output logic [cache_pkg::index_bits-1:0] bank_index,
	output logic [cache_pkg::block_words-1:0] bank_write_en,
	output logic [cache_pkg::word_bits-1:0] bank_write_data,
	output logic [cache_pkg::offset_bits-1:0] word_offset
);
	import cache_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;

	logic [sets-1:0] valid;
	logic [tag_bits-1:0] tags [sets];

	logic [offset_bits-1:0] fill_cnt; // word of the block being fetched
	logic hit;
	logic fill_last;
	cache_addr_t next_addr;           // address of the next memory request

	// paddr holds still for the whole transfer, so the banks follow it directly
	assign bank_index = paddr.fields.index;
	assign word_offset = paddr.fields.offset;

	assign hit = valid[paddr.fields.index] && (tags[paddr.fields.index] == paddr.fields.tag);

	// eighth word of the block is being returned
	assign fill_last = (state == fill) && mem_ready &&
		(fill_cnt == offset_bits'(block_words - 1));

	always_comb begin
		next_addr = paddr;
		next_addr.fields.byte_sel = 1'b0;
		if (state == fill)
			next_addr.fields.offset = fill_cnt + 1'b1;
		else if (!pwrite)
			next_addr.fields.offset = '0; // a fill starts at the top of the block
	end

	always_comb begin
		state_next = state;
		pready = 1'b0;
		bank_write_en = '0;
		bank_write_data = pwdata;

		case (state)
			idle: begin
				if (psel && !penable)
					state_next = lookup; // setup phase
			end

			lookup: begin
				if (pwrite) begin
					state_next = write_mem;
				end else if (hit) begin
					pready = 1'b1;   // read hit, zero wait states
					state_next = idle;
				end else begin
					state_next = fill;
				end
			end

			fill: begin
				bank_write_data = mem_read_data;
				if (mem_ready)
					bank_write_en[fill_cnt] = 1'b1;
				if (fill_last)
					state_next = fill_done;
			end

			// ends a write, or lets the banks settle after a fill
			fill_done: begin
				if (pwrite) begin
					pready = 1'b1;
					bank_write_en[paddr.fields.offset] = hit; // update only a cached word
					state_next = idle;
				end else begin
					state_next = lookup; // re-read, now a hit
				end
			end

			write_mem: begin
				if (mem_ready)
					state_next = fill_done;
			end

			default: state_next = idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= idle;
			fill_cnt <= '0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			valid <= '0;
		end else begin
			state <= state_next;

			if (state == lookup && !pwrite && !hit) begin
				mem_read <= 1'b1;
				fill_cnt <= '0;
			end
			if (state == lookup && pwrite)
				mem_write <= 1'b1;   // write-through, hit or miss

			if (state == fill && mem_ready)
				fill_cnt <= fill_cnt + 1'b1;
			if (fill_last) begin
				mem_read <= 1'b0;
				valid[paddr.fields.index] <= 1'b1;
			end

			if (state == write_mem && mem_ready)
				mem_write <= 1'b0;
		end
	end

	// request payload and tag store
	always_ff @(posedge clk) begin
		if (state == lookup) begin
			mem_addr <= next_addr.word;
			mem_write_data <= pwdata;
		end else if (state == fill && mem_ready) begin
			mem_addr <= next_addr.word; // step to the next word of the block
		end

		if (fill_last)
			tags[paddr.fields.index] <= paddr.fields.tag;
	end

endmodule

`default_nettype wire

/* logic/cache_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_top (
	input  logic clk,
	input  logic rst_n,

	// apb slave
	input  logic psel,
	input  logic penable,
	input  logic pwrite,
	input  logic [cache_pkg::word_bits-1:0] paddr,
	input  logic [cache_pkg::word_bits-1:0] pwdata,
	output logic [cache_pkg::word_bits-1:0] prdata,
	output logic pready,

	// memory port
	input  logic mem_ready,
	input  logic [cache_pkg::word_bits-1:0] mem_read_data,
	output logic mem_read,
	output logic mem_write,
	output logic [cache_pkg::word_bits-1:0] mem_addr,
	output logic [cache_pkg::word_bits-1:0] mem_write_data
);
	import cache_pkg::*;

	logic [index_bits-1:0] bank_index;
	logic [block_words-1:0] bank_write_en;
	logic [word_bits-1:0] bank_write_data;
	logic [offset_bits-1:0] word_offset;
	logic [word_bits-1:0] bank_read_data [block_words];

	cache_ctrl cache_ctrl_inst (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.pready(pready),
		.mem_ready(mem_ready),
		.mem_read_data(mem_read_data),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_write_data(mem_write_data),
		.bank_index(bank_index),
		.bank_write_en(bank_write_en),
		.bank_write_data(bank_write_data),
		.word_offset(word_offset)
	);

	// one bank per word offset, all addressed by the same set
	generate
		for (genvar i = 0; i < block_words; i++) begin : bank_gen
			word_bank word_bank_inst (
				.clk(clk),
				.write_en(bank_write_en[i]),
				.index(bank_index),
				.write_data(bank_write_data),
				.read_data(bank_read_data[i])
			);
		end
	endgenerate

	read_select read_select_inst (
		.clk(clk),
		.rst_n(rst_n),
		.word_offset(word_offset),
		.bank_words(bank_read_data),
		.prdata(prdata)
	);

endmodule

`default_nettype wire

/* verif/cache_props.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_props (
	input logic clk,
	input logic rst_n,
	input logic psel,
	input logic penable,
	input logic pready,
	input logic mem_read,
	input logic mem_write,
	input logic mem_ready,
	input logic [cache_pkg::word_bits-1:0] mem_addr,
	input logic [cache_pkg::word_bits-1:0] mem_write_data
);

	int fail_count = 0; // failures so far

	// pready only inside an access phase
	pready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
		pready |-> (psel && penable))
	else begin
		fail_count = fail_count + 1;
		$error("pready high outside an apb access phase");
	end

	one_request_kind: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_read && mem_write))
	else begin
		fail_count = fail_count + 1;
		$error("mem_read and mem_write high together");
	end

	// a pending request keeps its address until memory answers
	read_held: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_read && !mem_ready) |=> (mem_read && $stable(mem_addr)))
	else begin
		fail_count = fail_count + 1;
		$error("memory read request changed before mem_ready");
	end

	write_held: assert property (@(posedge clk) disable iff (!rst_n)
		(mem_write && !mem_ready) |=>
		(mem_write && $stable(mem_addr) && $stable(mem_write_data)))
	else begin
		fail_count = fail_count + 1;
		$error("memory write request changed before mem_ready");
	end

endmodule

bind cache_ctrl cache_props cache_props_inst (
	.clk(clk),
	.rst_n(rst_n),
	.psel(psel),
	.penable(penable),
	.pready(pready),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.mem_ready(mem_ready),
	.mem_addr(mem_addr),
	.mem_write_data(mem_write_data)
);

`default_nettype wire

/* verif/cache_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module cache_tb;
	import cache_pkg::*;

	localparam int num_trans = 400;
	// 8 words x (3 wait + 2) plus 10 cycles of margin per transaction
	localparam int cycle_limit = num_trans * 50;
	localparam int pool_size = 6;
	localparam int mem_words = 2**15;

	logic clk;
	logic rst_n;
	logic psel;
	logic penable;
	logic pwrite;
	logic [word_bits-1:0] paddr;
	logic [word_bits-1:0] pwdata;
	logic [word_bits-1:0] prdata;
	logic pready;
	logic mem_ready;
	logic [word_bits-1:0] mem_read_data;
	logic mem_read;
	logic mem_write;
	logic [word_bits-1:0] mem_addr;
	logic [word_bits-1:0] mem_write_data;

	logic [word_bits-1:0] ext_mem [mem_words]; // memory behind the port
	logic [word_bits-1:0] ref_mem [mem_words]; // what the cpu expects to read
	logic model_valid [sets];
	logic [tag_bits-1:0] model_tag [sets];
	logic [word_bits-1:0] pool [pool_size];    // block bases paired per set

	logic [word_bits-1:0] read_addr_q [$];
	logic [word_bits-1:0] write_addr_q [$];
	logic [word_bits-1:0] write_data_q [$];
	int cycle_count = 0;

	cache_top cache_top_inst (
		.clk(clk),
		.rst_n(rst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.mem_ready(mem_ready),
		.mem_read_data(mem_read_data),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_write_data(mem_write_data)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cache_top_inst.cache_ctrl_inst.cache_props_inst.fail_count != 0) begin
			$display("A handshake assertion failed");
			$display("Errors found");
			$fatal(1, "stopping at the first assertion failure");
		end else if (cycle_count > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Errors found");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// completed memory handshakes
	always @(posedge clk) begin
		if (rst_n && mem_ready) begin
			if (mem_read)
				read_addr_q.push_back(mem_addr);
			if (mem_write) begin
				write_addr_q.push_back(mem_addr);
				write_data_q.push_back(mem_write_data);
			end
		end
	end

	// memory responder with 0 to 3 wait cycles
	initial begin : responder
		int delay;
		mem_ready = 1'b0;
		mem_read_data = '0;
		forever begin
			@(posedge clk);
			if (mem_ready) begin
				#1;
				mem_ready = 1'b0;
			end else if (rst_n && (mem_read || mem_write)) begin
				delay = $urandom_range(3, 0);
				repeat (delay) @(posedge clk);
				#1;
				if (mem_write)
					ext_mem[mem_addr[15:1]] = mem_write_data;
				else
					mem_read_data = ext_mem[mem_addr[15:1]];
				mem_ready = 1'b1;
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Error: %s is %h, expected %h", name, actual, expected);
			$display("Errors found");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic apb_transfer(input logic write, input logic [15:0] addr,
		input logic [15:0] wdata, output logic [15:0] rdata, output int waits);
		@(posedge clk);
		#1;
		psel = 1'b1; // setup phase
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(posedge clk);
		#1;
		penable = 1'b1;
		waits = 0;
		@(posedge clk);
		while (!pready) begin
			waits++;
			@(posedge clk);
		end
		rdata = prdata;
		#1;
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic clear_traffic();
		read_addr_q.delete();
		write_addr_q.delete();
		write_data_q.delete();
	endtask

	task automatic read_and_check(input logic [15:0] addr);
		logic [tag_bits-1:0] tag;
		logic [index_bits-1:0] index;
		logic predicted_hit;
		logic [15:0] rdata;
		int waits;
		tag = addr[15:11];
		index = addr[10:4];
		predicted_hit = model_valid[index] && (model_tag[index] == tag);
		clear_traffic();
		apb_transfer(1'b0, addr, 16'($urandom), rdata, waits);
		check_value("prdata", rdata, ref_mem[addr[15:1]]);
		check_value("mem_read", mem_read, 0);
		check_value("mem_write", mem_write, 0);
		check_value("mem_write count on read", write_addr_q.size(), 0);
		if (predicted_hit) begin
			check_value("pready wait cycles on hit", waits, 0);
			check_value("mem_read count on hit", read_addr_q.size(), 0);
		end else begin
			check_value("mem_read count on miss", read_addr_q.size(), block_words);
			for (int k = 0; k < block_words; k++)
				check_value("fill mem_addr", read_addr_q[k], {tag, index, 3'(k), 1'b0});
			model_valid[index] = 1'b1;
			model_tag[index] = tag;
		end
	endtask

	task automatic write_and_check(input logic [15:0] addr, input logic [15:0] data);
		logic [15:0] rdata;
		int waits;
		clear_traffic();
		apb_transfer(1'b1, addr, data, rdata, waits);
		ref_mem[addr[15:1]] = data; // write-through keeps memory current
		check_value("mem_write", mem_write, 0);
		check_value("mem_read count on write", read_addr_q.size(), 0);
		check_value("mem_write count", write_addr_q.size(), 1);
		check_value("mem_addr on write", write_addr_q[0], {addr[15:1], 1'b0});
		check_value("mem_write_data", write_data_q[0], data);
	endtask

	initial begin : stimulus
		logic [15:0] addr;
		logic [15:0] last_addr;
		logic [index_bits-1:0] set_pick;
		logic is_write;
		void'($urandom(32'he7503622));
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		last_addr = '0;
		set_pick = '0;
		for (int i = 0; i < mem_words; i++) begin
			ext_mem[i] = 16'($urandom);
			ref_mem[i] = ext_mem[i];
		end
		for (int s = 0; s < sets; s++) begin
			model_valid[s] = 1'b0;
			model_tag[s] = '0;
		end
		// two tags per set so that blocks evict each other
		for (int p = 0; p < pool_size; p++) begin
			if (p % 2 == 0)
				set_pick = 7'($urandom);
			pool[p] = {5'($urandom), set_pick, 4'b0000};
		end

		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		check_value("pready after reset", pready, 0);
		check_value("mem_read after reset", mem_read, 0);
		check_value("mem_write after reset", mem_write, 0);
		check_value("prdata after reset", prdata, 0);

		for (int n = 0; n < num_trans; n++) begin
			if (n > 0 && $urandom_range(3, 0) == 0)
				addr = last_addr; // often reads back what was just written
			else if ($urandom_range(4, 0) != 0)
				addr = pool[$urandom_range(pool_size - 1, 0)] | 16'($urandom_range(15, 0));
			else
				addr = 16'($urandom);
			is_write = ($urandom_range(2, 0) == 0);
			if (is_write)
				write_and_check(addr, 16'($urandom));
			else
				read_and_check(addr);
			last_addr = addr;
		end

		if (cache_top_inst.cache_ctrl_inst.cache_props_inst.fail_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Handshake assertions failed during the run");
			$display("Errors found");
			$fatal(1, "run ended with assertion failures");
		end
	end

endmodule

`default_nettype wire

/* sources.f */
logic/cache_pkg.sv
logic/word_bank.sv
logic/read_select.sv
logic/cache_ctrl.sv
logic/cache_top.sv
verif/cache_props.sv
verif/cache_tb.sv
